//--- verilog.f
+incdir+include
source/cpuPkg.sv
source/controlUnit.sv
source/registerFile.sv
source/branchUnit.sv
source/decodeStage.sv
source/idExRegister.sv
source/decodeTop.sv
test/decodeTop_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = decodeTop_tb
FILELIST = verilog.f
OBJDIR   = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- test/decodeTop_tb.sv
////////////////////
// Table-driven testbench for the decode stage and ID/EX register.
// Register contents build up row by row through write-back.
// outReady stalls come from $random with a fixed seed.
////////////////////
`timescale 1ns/1ps

module decodeTop_tb;

    import cpuPkg::*;

    localparam int MaxRows = 64;

    logic           clk;
    logic           reset;
    logic           inValid;
    logic           inReady;
    fetchPacket_t   fetch;
    wbPacket_t      wb;
    flags_t         flags;
    logic           outValid;
    logic           outReady;
    decodedPacket_t decoded;

    // One entry per row of the table
    string      rowName  [MaxRows];
    word_t      rowInstr [MaxRows];
    word_t      rowPc    [MaxRows];
    flags_t     rowFlags [MaxRows];
    wbPacket_t  rowWb    [MaxRows];
    word_t      expData1 [MaxRows];
    word_t      expData2 [MaxRows];
    word_t      expImm   [MaxRows];
    word_t      expNewPc [MaxRows];
    logic       expTaken [MaxRows];
    logic       expHalt  [MaxRows];
    logic [7:0] expCtrl  [MaxRows];
    logic [7:0] expRegs  [MaxRows];
    int         numRows;
    wbPacket_t  pendingWb;

    int         pending[$];
    int         cycleCount;
    integer     seed;
    logic       modelFull;

    decodeTop UUT (
        .clk     (clk),
        .reset   (reset),
        .inValid (inValid),
        .inReady (inReady),
        .fetch   (fetch),
        .wb      (wb),
        .flags   (flags),
        .outValid(outValid),
        .outReady(outReady),
        .decoded (decoded)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic checkValue(input string testName, input string what,
                              input logic [15:0] expected, input logic [15:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s %s: expected %h, actual %h", testName, what, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch in %s", testName);
        end
    endtask

    // Branch select encoding 01 for B, 10 for BR and 11 for HLT
    function automatic logic [1:0] branchSelFor(input logic [3:0] opcode);
        logic [1:0] sel;
        case (opcode)
            4'hC:    sel = 2'b01;
            4'hD:    sel = 2'b10;
            4'hF:    sel = 2'b11;
            default: sel = 2'b00;
        endcase
        return sel;
    endfunction

    // Loads and stores add base and offset
    function automatic logic [3:0] aluOpFor(input logic [3:0] opcode);
        return (opcode == 4'h8 || opcode == 4'h9) ? 4'h0 : opcode;
    endfunction

    // Write-back that rides along with the next row added
    task automatic queueWriteBack(input int wrReg, input int wrData);
        pendingWb.wrEn   = 1'b1;
        pendingWb.wrReg  = 4'(wrReg);
        pendingWb.wrData = 16'(wrData);
    endtask

    // Ctrl bits in order regWrite aluSrc memEnable memWrite memToReg pcRead rdSrc aluSext
    // regs is {srcReg1, srcReg2}
    task automatic addRow(input string name, input int instr, input int pc, input int fl,
                          input int data1, input int data2, input int imm, input int newPc,
                          input int taken, input int halt, input int ctrl, input int regs);
        rowName[numRows]  = name;
        rowInstr[numRows] = 16'(instr);
        rowPc[numRows]    = 16'(pc);
        rowFlags[numRows] = 3'(fl);
        rowWb[numRows]    = pendingWb;
        expData1[numRows] = 16'(data1);
        expData2[numRows] = 16'(data2);
        expImm[numRows]   = 16'(imm);
        expNewPc[numRows] = 16'(newPc);
        expTaken[numRows] = 1'(taken);
        expHalt[numRows]  = 1'(halt);
        expCtrl[numRows]  = 8'(ctrl);
        expRegs[numRows]  = 8'(regs);
        pendingWb         = '0;
        numRows++;
    endtask

    task automatic buildTable();
        // Register file after reset and preloads through write-back
        addRow("reset_read",     'h0123, 'h002, 'b000, 0, 0, 'h0003, 'h002, 0, 0, 'h80, 'h23);
        queueWriteBack(2, 'h1234);
        addRow("bypass_r2",      'h0123, 'h004, 'b000, 'h1234, 0, 'h3, 'h004, 0, 0, 'h80, 'h23);
        queueWriteBack(3, 'hABCD);
        addRow("preload_r3",     'h0425, 'h006, 'b000, 'h1234, 0, 'h5, 'h006, 0, 0, 'h80, 'h25);
        queueWriteBack(5, 'h8001);
        addRow("preload_r5",     'h0637, 'h008, 'b000, 'hABCD, 0, 'h7, 'h008, 0, 0, 'h80, 'h37);
        queueWriteBack(7, 'h00F0);
        addRow("preload_r7",     'h0859, 'h00A, 'b000, 'h8001, 0, 'hFFF9, 'h00A, 0, 0, 'h80, 'h59);
        addRow("add_readback",   'h0123, 'h00C, 'b000, 'h1234, 'hABCD, 'h3, 'h00C, 0, 0, 'h80, 'h23);
        queueWriteBack(2, 'h5555);
        addRow("bypass_both",    'h1122, 'h00E, 'b000, 'h5555, 'h5555, 'h2, 'h00E, 0, 0, 'h80, 'h22);
        queueWriteBack(0, 'hFFFF);
        addRow("write_r0",       'h0100, 'h010, 'b000, 0, 0, 0, 'h010, 0, 0, 'h80, 'h00);
        addRow("r0_stays_zero",  'h2102, 'h012, 'b000, 0, 'h5555, 'h2, 'h012, 0, 0, 'h80, 'h02);
        // Memory, byte loads, shifts and PCS
        addRow("lw",             'h8435, 'h014, 'b000, 'hABCD, 'h8001, 'h5, 'h014, 0, 0, 'hE8, 'h35);
        addRow("sw_reads_rd",    'h972D, 'h016, 'b000, 'h5555, 'h00F0, 'hFFFD, 'h016, 0, 0, 'h70, 'h27);
        addRow("llb",            'hA5A7, 'h018, 'b000, 'h8001, 'h00F0, 'hA7, 'h018, 0, 0, 'hC3, 'h57);
        addRow("lhb",            'hB3FE, 'h01A, 'b000, 'hABCD, 0, 'hFE, 'h01A, 0, 0, 'hC3, 'h3E);
        addRow("sll_imm",        'h4174, 'h01C, 'b000, 'h00F0, 0, 'h4, 'h01C, 0, 0, 'hC0, 'h74);
        addRow("sra_neg_imm",    'h5128, 'h01E, 'b000, 'h5555, 0, 'hFFF8, 'h01E, 0, 0, 'hC0, 'h28);
        addRow("ror_imm",        'h615F, 'h020, 'b000, 'h8001, 0, 'hFFFF, 'h020, 0, 0, 'hC0, 'h5F);
        addRow("pcs",            'hE9AB, 'h022, 'b000, 'h0022, 0, 'hFFFB, 'h022, 0, 0, 'h84, 'h00);
        // B with offset +16 words and flags as {Z, V, N}
        addRow("b_ne_true",      'hC010, 'h200, 'b000, 0, 0, 0, 'h220, 1, 0, 'h00, 'h10);
        addRow("b_ne_false",     'hC010, 'h200, 'b100, 0, 0, 0, 'h200, 0, 0, 'h00, 'h10);
        addRow("b_eq_true",      'hC210, 'h200, 'b100, 0, 0, 0, 'h220, 1, 0, 'h00, 'h10);
        addRow("b_eq_false",     'hC210, 'h200, 'b000, 0, 0, 0, 'h200, 0, 0, 'h00, 'h10);
        addRow("b_gt_true",      'hC410, 'h200, 'b010, 0, 0, 0, 'h220, 1, 0, 'h00, 'h10);
        addRow("b_gt_false",     'hC410, 'h200, 'b001, 0, 0, 0, 'h200, 0, 0, 'h00, 'h10);
        addRow("b_lt_true",      'hC610, 'h200, 'b001, 0, 0, 0, 'h220, 1, 0, 'h00, 'h10);
        addRow("b_lt_false",     'hC610, 'h200, 'b100, 0, 0, 0, 'h200, 0, 0, 'h00, 'h10);
        addRow("b_ge_true",      'hC810, 'h200, 'b100, 0, 0, 0, 'h220, 1, 0, 'h00, 'h10);
        addRow("b_ge_false",     'hC810, 'h200, 'b001, 0, 0, 0, 'h200, 0, 0, 'h00, 'h10);
        addRow("b_le_true",      'hCA10, 'h200, 'b001, 0, 0, 0, 'h220, 1, 0, 'h00, 'h10);
        addRow("b_le_false",     'hCA10, 'h200, 'b010, 0, 0, 0, 'h200, 0, 0, 'h00, 'h10);
        addRow("b_ovf_true",     'hCC10, 'h200, 'b010, 0, 0, 0, 'h220, 1, 0, 'h00, 'h10);
        addRow("b_ovf_false",    'hCC10, 'h200, 'b101, 0, 0, 0, 'h200, 0, 0, 'h00, 'h10);
        addRow("b_always",       'hCE10, 'h200, 'b000, 0, 0, 0, 'h220, 1, 0, 'h00, 'h10);
        // Offset -16 words
        addRow("b_lt_back",      'hC7F0, 'h200, 'b001, 0, 0, 0, 'h1E0, 1, 0, 'h00, 'hF0);
        addRow("b_ne_back_false",'hC1F0, 'h200, 'b100, 0, 0, 0, 'h200, 0, 0, 'h00, 'hF0);
        // BR targets come from rs
        addRow("br_always",      'hDE20, 'h300, 'b000, 'h5555, 0, 0, 'h5555, 1, 0, 'h00, 'h20);
        addRow("br_eq_false",    'hD230, 'h300, 'b000, 'hABCD, 0, 0, 'h300, 0, 0, 'h00, 'h30);
        addRow("br_lt_true",     'hD670, 'h300, 'b001, 'h00F0, 0, 0, 'h00F0, 1, 0, 'h00, 'h70);
        addRow("hlt",            'hFE00, 'h400, 'b111, 0, 0, 0, 'h400, 0, 1, 'h00, 'h00);
    endtask

    task automatic comparePacket(input int idx);
        logic [7:0] ctrlBits;
        ctrlBits = {decoded.ctrl.regWrite, decoded.ctrl.aluSrc, decoded.ctrl.memEnable,
                    decoded.ctrl.memWrite, decoded.ctrl.memToReg, decoded.ctrl.pcRead,
                    decoded.ctrl.rdSrc, decoded.ctrl.aluSext};
        checkValue(rowName[idx], "srcData1", expData1[idx], decoded.srcData1);
        checkValue(rowName[idx], "srcData2", expData2[idx], decoded.srcData2);
        checkValue(rowName[idx], "imm", expImm[idx], decoded.imm);
        checkValue(rowName[idx], "newPc", expNewPc[idx], decoded.newPc);
        checkValue(rowName[idx], "taken", 16'(expTaken[idx]), 16'(decoded.taken));
        checkValue(rowName[idx], "halt", 16'(expHalt[idx]), 16'(decoded.halt));
        checkValue(rowName[idx], "ctrl", 16'(expCtrl[idx]), 16'(ctrlBits));
        checkValue(rowName[idx], "branch", 16'(branchSelFor(rowInstr[idx][15:12])),
                   16'(decoded.ctrl.branch));
        checkValue(rowName[idx], "aluOp", 16'(aluOpFor(rowInstr[idx][15:12])),
                   16'(decoded.ctrl.aluOp));
        checkValue(rowName[idx], "srcRegs", 16'(expRegs[idx]),
                   16'({decoded.srcReg1, decoded.srcReg2}));
        checkValue(rowName[idx], "dstReg", 16'(rowInstr[idx][11:8]), 16'(decoded.dstReg));
    endtask

    // Limit scales with the table, stalls included
    always @(posedge clk) begin
        if (reset) begin
            cycleCount <= 0;
        end else begin
            cycleCount <= cycleCount + 1;
            if (cycleCount > 3 * numRows + 50) begin
                $display("=== FAIL ===");
                $fatal(1, "timeout: the decode pipeline stopped delivering packets");
            end
        end
    end

    initial begin
        int   rowIdx;
        logic accepted;
        seed      = 32'h868a3351;
        numRows   = 0;
        pendingWb = '0;
        reset     = 1'b1;
        inValid   = 1'b0;
        fetch     = '0;
        wb        = '0;
        flags     = '0;
        outReady  = 1'b0;
        modelFull = 1'b0;
        rowIdx    = 0;
        buildTable();
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        while (rowIdx < numRows || pending.size() != 0) begin
            if (rowIdx < numRows) begin
                inValid     = 1'b1;
                fetch.instr = rowInstr[rowIdx];
                fetch.pc    = rowPc[rowIdx];
                flags       = rowFlags[rowIdx];
                wb          = rowWb[rowIdx];
            end else begin
                inValid = 1'b0;
                wb      = '0;
            end
            // Stall about one cycle in four
            outReady = ($random(seed) & 3) != 0;

            @(negedge clk);
            checkValue("handshake", "outValid", 16'(modelFull), 16'(outValid));
            checkValue("handshake", "inReady", 16'(!modelFull || outReady), 16'(inReady));
            if (outValid && outReady) begin
                comparePacket(pending.pop_front());
            end
            accepted = inValid && inReady;
            if (accepted) begin
                pending.push_back(rowIdx);
            end
            modelFull = accepted || (modelFull && !outReady);

            @(posedge clk);
            #1;
            if (accepted) begin
                rowIdx++;
            end
        end

        inValid = 1'b0;
        wb      = '0;
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- source/decodeTop.sv
////////////////////
// Decode stage plus its output register.
// One cycle latency.
////////////////////
`timescale 1ns/1ps

module decodeTop (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   inValid,
    output logic                   inReady,
    input  cpuPkg::fetchPacket_t   fetch,
    input  cpuPkg::wbPacket_t      wb,
    input  cpuPkg::flags_t         flags,
    output logic                   outValid,
    input  logic                   outReady,
    output cpuPkg::decodedPacket_t decoded
);

    import cpuPkg::*;

    decodedPacket_t stageOut;

    decodeStage stage (
        .clk    (clk),
        .reset  (reset),
        .fetch  (fetch),
        .wb     (wb),
        .flags  (flags),
        .decoded(stageOut)
    );

    idExRegister idEx (
        .clk      (clk),
        .reset    (reset),
        .inValid  (inValid),
        .inReady  (inReady),
        .inPacket (stageOut),
        .outValid (outValid),
        .outReady (outReady),
        .outPacket(decoded)
    );

endmodule

//--- source/idExRegister.sv
////////////////////
// Single-entry decode/execute register.
// Full throughput when outReady stays high.
////////////////////
`timescale 1ns/1ps

module idExRegister (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   inValid,
    output logic                   inReady,
    input  cpuPkg::decodedPacket_t inPacket,
    output logic                   outValid,
    input  logic                   outReady,
    output cpuPkg::decodedPacket_t outPacket
);

    logic load;

    // Room when empty or when the held packet leaves this cycle
    assign inReady = !outValid || outReady;
    assign load    = inValid && inReady;

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
        end else if (load) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            outPacket <= inPacket;
        end
    end

    // Stalled packet must not change under the consumer
    assert property (@(posedge clk) disable iff (reset)
        (outValid && !outReady) |=> (outValid && $stable(outPacket)))
        else $error("ID/EX packet changed while stalled");

endmodule

//--- source/decodeStage.sv
////////////////////
// Combinational decode, zero cycles from fetch to packet.
// Only the register file holds state.
////////////////////
`timescale 1ns/1ps
`include "cpu_defs.svh"

module decodeStage (
    input  logic                   clk,
    input  logic                   reset,
    input  cpuPkg::fetchPacket_t   fetch,
    input  cpuPkg::wbPacket_t      wb,
    input  cpuPkg::flags_t         flags,
    output cpuPkg::decodedPacket_t decoded
);

    import cpuPkg::*;

    ctrl_t    ctrl;
    opcode_t  opcode;
    regAddr_t dstReg;
    regAddr_t srcReg1;
    regAddr_t srcReg2;
    word_t    rfData1;
    word_t    rfData2;
    word_t    srcData1;
    word_t    imm;
    word_t    offset;
    word_t    newPc;
    logic [2:0] cond;
    logic     taken;

    assign opcode = fetch.instr[`DATA_WIDTH-1 -: `OPCODE_WIDTH];

    controlUnit control (
        .opcode(opcode),
        .ctrl  (ctrl)
    );

    assign dstReg = fetch.instr[11:8];

    // LLB/LHB read rd, PCS reads nothing
    assign srcReg1 = ctrl.pcRead ? '0 :
                     ctrl.rdSrc  ? dstReg : fetch.instr[7:4];
    // SW reads the stored register on port 2
    assign srcReg2 = ctrl.pcRead   ? '0 :
                     ctrl.memWrite ? dstReg : fetch.instr[3:0];

    // 8-bit for byte loads, 4-bit signed for the rest
    assign imm = ctrl.aluSext ?
                 {{(`DATA_WIDTH-8){1'b0}}, fetch.instr[7:0]} :
                 {{(`DATA_WIDTH-4){fetch.instr[3]}}, fetch.instr[3:0]};

    registerFile regFile (
        .clk     (clk),
        .reset   (reset),
        .srcReg1 (srcReg1),
        .srcReg2 (srcReg2),
        .wb      (wb),
        .srcData1(rfData1),
        .srcData2(rfData2)
    );

    assign srcData1 = ctrl.pcRead ? fetch.pc : rfData1;

    // Word offset, so shift left once
    assign cond   = fetch.instr[11:9];
    assign offset = {{(`DATA_WIDTH-10){fetch.instr[8]}}, fetch.instr[8:0], 1'b0};

    branchUnit branch (
        .branch   (ctrl.branch),
        .cond     (cond),
        .offset   (offset),
        .regTarget(srcData1),
        .pc       (fetch.pc),
        .flags    (flags),
        .newPc    (newPc),
        .taken    (taken)
    );

    always_comb begin
        decoded.ctrl     = ctrl;
        decoded.srcReg1  = srcReg1;
        decoded.srcReg2  = srcReg2;
        decoded.dstReg   = dstReg;
        decoded.srcData1 = srcData1;
        decoded.srcData2 = rfData2;
        decoded.imm      = imm;
        decoded.newPc    = newPc;
        decoded.taken    = taken;
        decoded.halt     = (ctrl.branch == `BRANCH_HALT);
    end

endmodule

//--- source/branchUnit.sv
////////////////////
// Next-PC logic for B and BR.
// offset arrives already shifted and sign-extended.
////////////////////
`timescale 1ns/1ps
`include "cpu_defs.svh"

module branchUnit (
    input  cpuPkg::branchSel_t branch,
    input  logic [2:0]         cond,
    input  cpuPkg::word_t      offset,
    input  cpuPkg::word_t      regTarget,
    input  cpuPkg::word_t      pc,
    input  cpuPkg::flags_t     flags,
    output cpuPkg::word_t      newPc,
    output logic               taken
);

    logic zFlag;
    logic vFlag;
    logic nFlag;
    logic condMet;
    logic isBranch;

    assign zFlag = flags[2];
    assign vFlag = flags[1];
    assign nFlag = flags[0];

    always_comb begin
        case (cond)
            `COND_NE:     condMet = !zFlag;
            `COND_EQ:     condMet = zFlag;
            `COND_GT:     condMet = !zFlag && !nFlag;
            `COND_LT:     condMet = nFlag;
            `COND_GE:     condMet = zFlag || (!zFlag && !nFlag);
            `COND_LE:     condMet = nFlag || zFlag;
            `COND_OVF:    condMet = vFlag;
            `COND_UNCOND: condMet = 1'b1;
            default:      condMet = 1'b0;
        endcase
    end

    // halt and plain instructions never redirect
    assign isBranch = (branch == `BRANCH_B) || (branch == `BRANCH_BR);
    assign taken    = isBranch && condMet;

    always_comb begin
        if (!taken) begin
            newPc = pc;
        end else if (branch == `BRANCH_B) begin
            newPc = pc + offset;
        end else begin
            newPc = regTarget;
        end
    end

endmodule

//--- source/registerFile.sv
////////////////////
// Sixteen words, two read ports, one write port.
// R0 is hardwired to zero.
// Reads see a same-cycle write (bypass).
////////////////////
`timescale 1ns/1ps
`include "cpu_defs.svh"

module registerFile (
    input  logic              clk,
    input  logic              reset,
    input  cpuPkg::regAddr_t  srcReg1,
    input  cpuPkg::regAddr_t  srcReg2,
    input  cpuPkg::wbPacket_t wb,
    output cpuPkg::word_t     srcData1,
    output cpuPkg::word_t     srcData2
);

    import cpuPkg::*;

    word_t regs [`REG_COUNT];

    // Write data wins over the stored value when numbers match
    function automatic word_t readPort(input regAddr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wb.wrEn && (wb.wrReg == addr)) begin
            value = wb.wrData;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.wrEn && (wb.wrReg != '0)) begin
            regs[wb.wrReg] <= wb.wrData;
        end
    end

    always_comb begin
        srcData1 = readPort(srcReg1);
        srcData2 = readPort(srcReg2);
    end

    // Write-back stage must present a defined register number
    assert property (@(posedge clk) disable iff (reset)
        wb.wrEn |-> !$isunknown(wb.wrReg))
        else $error("write-back with unknown wrReg");

endmodule

//--- source/controlUnit.sv
////////////////////
// Purely combinational opcode decode.
// aluOp is the opcode itself except for LW/SW, which add.
////////////////////
`timescale 1ns/1ps
`include "cpu_defs.svh"

module controlUnit (
    input  cpuPkg::opcode_t opcode,
    output cpuPkg::ctrl_t   ctrl
);

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = opcode;
        case (opcode)
            `OP_ADD, `OP_SUB, `OP_XOR, `OP_RED, `OP_PADDSB: begin
                ctrl.regWrite = 1'b1;
            end
            // Shift amount comes from the 4-bit immediate
            `OP_SLL, `OP_SRA, `OP_ROR: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            `OP_LW: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;
                ctrl.memEnable = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.aluOp     = `OP_ADD;
            end
            `OP_SW: begin
                ctrl.aluSrc    = 1'b1;
                ctrl.memEnable = 1'b1;
                ctrl.memWrite  = 1'b1;
                ctrl.aluOp     = `OP_ADD;
            end
            // Byte loads keep the other half of rd, so rd is also read
            `OP_LLB, `OP_LHB: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluSext  = 1'b1;
                ctrl.rdSrc    = 1'b1;
            end
            `OP_B: begin
                ctrl.branch = `BRANCH_B;
            end
            `OP_BR: begin
                ctrl.branch = `BRANCH_BR;
            end
            `OP_PCS: begin
                ctrl.regWrite = 1'b1;
                ctrl.pcRead   = 1'b1;
            end
            `OP_HLT: begin
                ctrl.branch = `BRANCH_HALT;
            end
            default: begin
                ctrl.branch = `BRANCH_NONE;
            end
        endcase
    end

    // A store must always go with a memory access
    always_comb begin
        assert (!ctrl.memWrite || ctrl.memEnable)
            else $error("memWrite without memEnable, opcode %0d", opcode);
    end

endmodule

//--- source/cpuPkg.sv
////////////////////
// Types shared by the decode stage and its neighbours.
// Flag order is zero, overflow, negative from bit 2 down.
////////////////////
`include "cpu_defs.svh"

package cpuPkg;

    typedef logic [`DATA_WIDTH-1:0]     word_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] regAddr_t;
    typedef logic [`OPCODE_WIDTH-1:0]   opcode_t;
    typedef logic [2:0]                 flags_t;
    typedef logic [1:0]                 branchSel_t;

    // Instruction from fetch with pc already incremented
    typedef struct packed {
        word_t instr;
        word_t pc;
    } fetchPacket_t;

    // Write-back request
    typedef struct packed {
        logic     wrEn;
        regAddr_t wrReg;
        word_t    wrData;
    } wbPacket_t;

    typedef struct packed {
        logic       regWrite;
        logic       aluSrc;
        logic       memEnable;
        logic       memWrite;
        logic       memToReg;
        logic       pcRead;
        logic       rdSrc;
        logic       aluSext;
        opcode_t    aluOp;
        branchSel_t branch;
    } ctrl_t;

    // Everything execute needs from decode
    typedef struct packed {
        ctrl_t    ctrl;
        regAddr_t srcReg1;
        regAddr_t srcReg2;
        regAddr_t dstReg;
        word_t    srcData1;
        word_t    srcData2;
        word_t    imm;
        word_t    newPc;
        logic     taken;
        logic     halt;
    } decodedPacket_t;

endpackage

//--- include/cpu_defs.svh
////////////////////
// Widths and encodings of the 16-bit ISA.
// The opcode numbers are fixed by the instruction set.
// The condition codes follow the B/BR cond field.
////////////////////
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Machine word and register file
`define DATA_WIDTH      16
`define REG_COUNT       16
`define REG_ADDR_WIDTH  4
`define OPCODE_WIDTH    4

// Opcodes
`define OP_ADD      4'd0
`define OP_SUB      4'd1
`define OP_XOR      4'd2
`define OP_RED      4'd3
`define OP_SLL      4'd4
`define OP_SRA      4'd5
`define OP_ROR      4'd6
`define OP_PADDSB   4'd7
`define OP_LW       4'd8
`define OP_SW       4'd9
`define OP_LLB      4'd10
`define OP_LHB      4'd11
`define OP_B        4'd12
`define OP_BR       4'd13
`define OP_PCS      4'd14
`define OP_HLT      4'd15

// Condition codes
`define COND_NE     3'd0
`define COND_EQ     3'd1
`define COND_GT     3'd2
`define COND_LT     3'd3
`define COND_GE     3'd4
`define COND_LE     3'd5
`define COND_OVF    3'd6
`define COND_UNCOND 3'd7

// Branch select
`define BRANCH_NONE 2'b00
`define BRANCH_B    2'b01
`define BRANCH_BR   2'b10
`define BRANCH_HALT 2'b11

`endif
